// File: src/synth_pkg.sv
package synth_pkg;

	localparam int NUM_VOICES = 4;
	localparam int NOTE_W = 6;
	localparam int PHASE_W = 16;
	localparam int SAMPLE_W = 4;
	localparam int OCT_W = 6;
	localparam int ADDR_W = 4;

	// byte addresses of the register block
	localparam logic [ADDR_W-1:0] ADDR_MASTER = 4'h0;
	localparam logic [ADDR_W-1:0] ADDR_VOICE = 4'h4;
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 4'h8;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// base note per one-hot octave bit, bit 0 first
	localparam logic [NOTE_W-1:0] OCT_BASE [OCT_W] = '{6'd3, 6'd5, 6'd6, 6'd8, 6'd10, 6'd12};
	localparam logic [NOTE_W-1:0] OCT_DEFAULT = 6'd1;
	localparam logic [NOTE_W-1:0] UPPER_OFFSET = 6'd12;

	// 64 * 2^(n/12), one octave doubles the step
	localparam logic [PHASE_W-1:0] PHASE_INC [49] = '{
		16'd0,   16'd68,  16'd72,  16'd76,  16'd81,  16'd85,  16'd91,
		16'd96,  16'd102, 16'd108, 16'd114, 16'd121, 16'd128, 16'd136,
		16'd144, 16'd152, 16'd161, 16'd171, 16'd181, 16'd192, 16'd203,
		16'd215, 16'd228, 16'd242, 16'd256, 16'd271, 16'd287, 16'd304,
		16'd323, 16'd342, 16'd362, 16'd384, 16'd406, 16'd431, 16'd456,
		16'd483, 16'd512, 16'd542, 16'd575, 16'd609, 16'd645, 16'd683,
		16'd724, 16'd767, 16'd813, 16'd861, 16'd912, 16'd967, 16'd1024
	};

	typedef struct packed {
		logic [16:0] spare;
		logic [7:0]  glide_div;
		logic        glide_en;
		logic [1:0]  volume;
		logic [3:0]  key_on;
	} master_cfg_t;

	typedef struct packed {
		logic [21:0] spare;
		logic [3:0]  wave_tri;
		logic [5:0]  octave;
	} voice_cfg_t;

	typedef union packed {
		master_cfg_t master;
		voice_cfg_t  voice;
		logic [31:0] raw;
	} reg_word_u;

endpackage

// File: src/synth_regs.sv
`timescale 1ns/10ps

module synth_regs
	import synth_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [ADDR_W-1:0]     awaddr,
	input  logic                  awvalid,
	output logic                  awready,
	input  logic [31:0]           wdata,
	input  logic [3:0]            wstrb,
	input  logic                  wvalid,
	output logic                  wready,
	output logic [1:0]            bresp,
	output logic                  bvalid,
	input  logic                  bready,
	input  logic [ADDR_W-1:0]     araddr,
	input  logic                  arvalid,
	output logic                  arready,
	output logic [31:0]           rdata,
	output logic [1:0]            rresp,
	output logic                  rvalid,
	input  logic                  rready,
	input  logic [NOTE_W-1:0]     note_0,
	input  logic [NOTE_W-1:0]     note_1,
	input  logic [NOTE_W-1:0]     note_2,
	input  logic [NOTE_W-1:0]     note_3,
	output logic [NUM_VOICES-1:0] key_on,
	output logic [OCT_W-1:0]      octave,
	output logic [NUM_VOICES-1:0] wave_tri,
	output logic [1:0]            volume,
	output logic                  glide_en,
	output logic [7:0]            glide_div
);

	reg_word_u   master_q;
	reg_word_u   voice_q;
	reg_word_u   wr_word;
	logic        wr_hs;
	logic        rd_hs;
	logic        resp_pend;
	logic [31:0] status_word;

	// byte-masked update of a stored word
	function automatic reg_word_u merge_strb(reg_word_u old_w, reg_word_u new_w,
		logic [3:0] strb);
		reg_word_u res;
		res = old_w;
		for (int i = 0; i < 4; i++)
		begin
			if (strb[i])
				res.raw[8*i +: 8] = new_w.raw[8*i +: 8];
		end
		return res;
	endfunction

	assign wr_word = wdata;
	assign resp_pend = bvalid | rvalid;

	// address and data are taken together, nothing new while a response waits
	assign wr_hs = awvalid & wvalid & ~resp_pend;
	assign rd_hs = arvalid & ~resp_pend;
	assign awready = wr_hs;
	assign wready = wr_hs;
	assign arready = rd_hs;

	// one byte lane per voice note
	assign status_word = {2'b00, note_3, 2'b00, note_2, 2'b00, note_1, 2'b00, note_0};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			master_q <= '0;
			voice_q <= '0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			if (wr_hs)
			begin
				bvalid <= 1'b1;
				case (awaddr)
					ADDR_MASTER: master_q <= merge_strb(master_q, wr_word, wstrb);
					ADDR_VOICE:  voice_q <= merge_strb(voice_q, wr_word, wstrb);
					default:     ;
				endcase
			end
			else if (bready)
				bvalid <= 1'b0;

			if (rd_hs)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// response payload
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			bresp <= RESP_OKAY;
			rresp <= RESP_OKAY;
			rdata <= '0;
		end
		else
		begin
			if (wr_hs)
				bresp <= (awaddr == ADDR_MASTER || awaddr == ADDR_VOICE) ?
					RESP_OKAY : RESP_SLVERR;
			if (rd_hs)
			begin
				rresp <= RESP_OKAY;
				case (araddr)
					ADDR_MASTER: rdata <= master_q.raw;
					ADDR_VOICE:  rdata <= voice_q.raw;
					ADDR_STATUS: rdata <= status_word;
					default:
					begin
						rdata <= '0;
						rresp <= RESP_SLVERR;
					end
				endcase
			end
		end
	end

	assign key_on = master_q.master.key_on;
	assign volume = master_q.master.volume;
	assign glide_en = master_q.master.glide_en;
	assign glide_div = master_q.master.glide_div;
	assign octave = voice_q.voice.octave;
	assign wave_tri = voice_q.voice.wave_tri;

endmodule

// File: src/note_select.sv
`timescale 1ns/10ps

module note_select
	import synth_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [NUM_VOICES-1:0] key_on,
	input  logic [OCT_W-1:0]      octave,
	output logic [NOTE_W-1:0]     target_0,
	output logic [NOTE_W-1:0]     target_1,
	output logic [NOTE_W-1:0]     target_2,
	output logic [NOTE_W-1:0]     target_3
);

	logic [NOTE_W-1:0] base;
	logic [NOTE_W-1:0] upper;

	// anything but a single octave bit falls back to the lowest note
	function automatic logic [NOTE_W-1:0] base_note(logic [OCT_W-1:0] oct);
		logic [NOTE_W-1:0] res;
		res = OCT_DEFAULT;
		if ($onehot(oct))
		begin
			for (int i = 0; i < OCT_W; i++)
			begin
				if (oct[i])
					res = OCT_BASE[i];
			end
		end
		return res;
	endfunction

	assign base = base_note(octave);
	assign upper = base + UPPER_OFFSET;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			target_0 <= '0;
			target_1 <= '0;
			target_2 <= '0;
			target_3 <= '0;
		end
		else
		begin
			target_0 <= key_on[0] ? base : '0;
			target_1 <= key_on[1] ? base : '0;
			// upper pair sounds an octave higher
			target_2 <= key_on[2] ? upper : '0;
			target_3 <= key_on[3] ? upper : '0;
		end
	end

endmodule

// File: src/portamento.sv
`timescale 1ns/10ps

module portamento
	import synth_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic [NOTE_W-1:0] target,
	input  logic              glide_en,
	input  logic [7:0]        glide_div,
	output logic [NOTE_W-1:0] note
);

	logic [7:0] div_cnt;
	logic       tick;

	// one step every glide_div+1 cycles
	assign tick = (div_cnt >= glide_div);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			div_cnt <= '0;
			note <= '0;
		end
		else
		begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;

			// key-off cuts at once, a fresh key-on starts at pitch
			if (!glide_en || target == '0 || note == '0)
				note <= target;
			else if (tick)
			begin
				if (note < target)
					note <= note + 1'b1;
				else if (note > target)
					note <= note - 1'b1;
			end
		end
	end

endmodule

// File: src/phase_gen.sv
`timescale 1ns/10ps

module phase_gen
	import synth_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic [NOTE_W-1:0]  note_0,
	input  logic [NOTE_W-1:0]  note_1,
	input  logic [NOTE_W-1:0]  note_2,
	input  logic [NOTE_W-1:0]  note_3,
	output logic [PHASE_W-1:0] phase_0,
	output logic [PHASE_W-1:0] phase_1,
	output logic [PHASE_W-1:0] phase_2,
	output logic [PHASE_W-1:0] phase_3
);

	logic [NOTE_W-1:0]  note_a [NUM_VOICES];
	logic [PHASE_W-1:0] phase_q [NUM_VOICES];

	// notes past the table top stay silent
	function automatic logic [PHASE_W-1:0] inc_of(logic [NOTE_W-1:0] n);
		if (int'(n) < $size(PHASE_INC))
			return PHASE_INC[n];
		return '0;
	endfunction

	assign note_a[0] = note_0;
	assign note_a[1] = note_1;
	assign note_a[2] = note_2;
	assign note_a[3] = note_3;

	always_ff @(posedge clk)
	begin
		for (int v = 0; v < NUM_VOICES; v++)
		begin
			// a silent voice restarts from zero phase
			if (rst || note_a[v] == '0)
				phase_q[v] <= '0;
			else
				phase_q[v] <= phase_q[v] + inc_of(note_a[v]);
		end
	end

	assign phase_0 = phase_q[0];
	assign phase_1 = phase_q[1];
	assign phase_2 = phase_q[2];
	assign phase_3 = phase_q[3];

endmodule

// File: src/wave_shaper.sv
`timescale 1ns/10ps

module wave_shaper
	import synth_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [PHASE_W-1:0]    phase_0,
	input  logic [PHASE_W-1:0]    phase_1,
	input  logic [PHASE_W-1:0]    phase_2,
	input  logic [PHASE_W-1:0]    phase_3,
	input  logic [NUM_VOICES-1:0] wave_tri,
	output logic [SAMPLE_W-1:0]   sample_0,
	output logic [SAMPLE_W-1:0]   sample_1,
	output logic [SAMPLE_W-1:0]   sample_2,
	output logic [SAMPLE_W-1:0]   sample_3
);

	logic [PHASE_W-1:0]  phase_a [NUM_VOICES];
	logic [SAMPLE_W-1:0] sample_q [NUM_VOICES];

	function automatic logic [SAMPLE_W-1:0] shape(logic [PHASE_W-1:0] ph, logic tri_sel);
		logic [SAMPLE_W:0] top;
		top = ph[PHASE_W-1 -: SAMPLE_W+1];
		if (!tri_sel)
			return {SAMPLE_W{ph[PHASE_W-1]}};
		// second half of the cycle runs back down
		return top[SAMPLE_W] ? ~top[SAMPLE_W-1:0] : top[SAMPLE_W-1:0];
	endfunction

	assign phase_a[0] = phase_0;
	assign phase_a[1] = phase_1;
	assign phase_a[2] = phase_2;
	assign phase_a[3] = phase_3;

	always_ff @(posedge clk)
	begin
		for (int v = 0; v < NUM_VOICES; v++)
		begin
			if (rst)
				sample_q[v] <= '0;
			else
				sample_q[v] <= shape(phase_a[v], wave_tri[v]);
		end
	end

	assign sample_0 = sample_q[0];
	assign sample_1 = sample_q[1];
	assign sample_2 = sample_q[2];
	assign sample_3 = sample_q[3];

endmodule

// File: src/voice_mixer.sv
`timescale 1ns/10ps

module voice_mixer
	import synth_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic [SAMPLE_W-1:0] sample_0,
	input  logic [SAMPLE_W-1:0] sample_1,
	input  logic [SAMPLE_W-1:0] sample_2,
	input  logic [SAMPLE_W-1:0] sample_3,
	input  logic [1:0]          volume,
	output logic [7:0]          audio_out
);

	logic [5:0] sum;
	logic [2:0] scale;
	logic [7:0] mix;

	// four voices peak at 60
	assign sum = 6'(sample_0) + 6'(sample_1) + 6'(sample_2) + 6'(sample_3);
	assign scale = volume + 1'b1;
	// 60 times 4 still fits in a byte
	assign mix = 8'(sum) * 8'(scale);

	always_ff @(posedge clk)
	begin
		if (rst)
			audio_out <= '0;
		else
			audio_out <= mix;
	end

endmodule

// File: src/synth_top.sv
`timescale 1ns/10ps

module synth_top
	import synth_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic [ADDR_W-1:0] awaddr,
	input  logic              awvalid,
	output logic              awready,
	input  logic [31:0]       wdata,
	input  logic [3:0]        wstrb,
	input  logic              wvalid,
	output logic              wready,
	output logic [1:0]        bresp,
	output logic              bvalid,
	input  logic              bready,
	input  logic [ADDR_W-1:0] araddr,
	input  logic              arvalid,
	output logic              arready,
	output logic [31:0]       rdata,
	output logic [1:0]        rresp,
	output logic              rvalid,
	input  logic              rready,
	output logic [7:0]        audio_out
);

	logic [NUM_VOICES-1:0] key_on;
	logic [OCT_W-1:0]      octave;
	logic [NUM_VOICES-1:0] wave_tri;
	logic [1:0]            volume;
	logic                  glide_en;
	logic [7:0]            glide_div;
	logic [NOTE_W-1:0]     target_0;
	logic [NOTE_W-1:0]     target_1;
	logic [NOTE_W-1:0]     target_2;
	logic [NOTE_W-1:0]     target_3;
	logic [NOTE_W-1:0]     note_0;
	logic [PHASE_W-1:0]    phase_0;
	logic [PHASE_W-1:0]    phase_1;
	logic [PHASE_W-1:0]    phase_2;
	logic [PHASE_W-1:0]    phase_3;
	logic [SAMPLE_W-1:0]   sample_0;
	logic [SAMPLE_W-1:0]   sample_1;
	logic [SAMPLE_W-1:0]   sample_2;
	logic [SAMPLE_W-1:0]   sample_3;

	synth_regs u_synth_regs (
		.clk       (clk),
		.rst       (rst),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.wvalid    (wvalid),
		.wready    (wready),
		.bresp     (bresp),
		.bvalid    (bvalid),
		.bready    (bready),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.note_0    (note_0),
		.note_1    (target_1),
		.note_2    (target_2),
		.note_3    (target_3),
		.key_on    (key_on),
		.octave    (octave),
		.wave_tri  (wave_tri),
		.volume    (volume),
		.glide_en  (glide_en),
		.glide_div (glide_div)
	);

	note_select u_note_select (
		.clk      (clk),
		.rst      (rst),
		.key_on   (key_on),
		.octave   (octave),
		.target_0 (target_0),
		.target_1 (target_1),
		.target_2 (target_2),
		.target_3 (target_3)
	);

	// only voice 0 glides
	portamento u_portamento (
		.clk       (clk),
		.rst       (rst),
		.target    (target_0),
		.glide_en  (glide_en),
		.glide_div (glide_div),
		.note      (note_0)
	);

	phase_gen u_phase_gen (
		.clk     (clk),
		.rst     (rst),
		.note_0  (note_0),
		.note_1  (target_1),
		.note_2  (target_2),
		.note_3  (target_3),
		.phase_0 (phase_0),
		.phase_1 (phase_1),
		.phase_2 (phase_2),
		.phase_3 (phase_3)
	);

	wave_shaper u_wave_shaper (
		.clk      (clk),
		.rst      (rst),
		.phase_0  (phase_0),
		.phase_1  (phase_1),
		.phase_2  (phase_2),
		.phase_3  (phase_3),
		.wave_tri (wave_tri),
		.sample_0 (sample_0),
		.sample_1 (sample_1),
		.sample_2 (sample_2),
		.sample_3 (sample_3)
	);

	voice_mixer u_voice_mixer (
		.clk       (clk),
		.rst       (rst),
		.sample_0  (sample_0),
		.sample_1  (sample_1),
		.sample_2  (sample_2),
		.sample_3  (sample_3),
		.volume    (volume),
		.audio_out (audio_out)
	);

endmodule

// File: sim/tb_synth.sv
`timescale 1ns/10ps

module tb_synth
	import synth_pkg::*;
();

	localparam int CYCLE_LIMIT = 20000;
	localparam int HS_LIMIT = 50;

	logic              clk;
	logic              rst;
	logic [ADDR_W-1:0] awaddr;
	logic              awvalid;
	logic              awready;
	logic [31:0]       wdata;
	logic [3:0]        wstrb;
	logic              wvalid;
	logic              wready;
	logic [1:0]        bresp;
	logic              bvalid;
	logic              bready;
	logic [ADDR_W-1:0] araddr;
	logic              arvalid;
	logic              arready;
	logic [31:0]       rdata;
	logic [1:0]        rresp;
	logic              rvalid;
	logic              rready;
	logic [7:0]        audio_out;

	int cycle_count = 0;
	int mismatch_count = 0;
	int fault_count = 0;

	synth_top u_synth_top (
		.clk       (clk),
		.rst       (rst),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.wvalid    (wvalid),
		.wready    (wready),
		.bresp     (bresp),
		.bvalid    (bvalid),
		.bready    (bready),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.audio_out (audio_out)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("run stopped after %0d cycles before the tests finished", cycle_count);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_sample(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_fault(input string msg);
		fault_count++;
		$display("ERROR: %s", msg);
	endtask

	// base note of a one-hot octave, 1 for anything else
	function automatic logic [NOTE_W-1:0] expected_base(input logic [OCT_W-1:0] oct);
		case (oct)
			6'h01: return 6'd3;
			6'h02: return 6'd5;
			6'h04: return 6'd6;
			6'h08: return 6'd8;
			6'h10: return 6'd10;
			6'h20: return 6'd12;
			default: return 6'd1;
		endcase
	endfunction

	// status word, one byte per voice
	function automatic logic [31:0] pack_notes(input logic [NOTE_W-1:0] n0, n1, n2, n3);
		return {2'b00, n3, 2'b00, n2, 2'b00, n1, 2'b00, n0};
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		int waited;
		waited = 0;
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		// ready seen at the edge that takes the handshake
		@(posedge clk);
		while (!(awready && wready) && waited < HS_LIMIT)
		begin
			waited++;
			@(posedge clk);
		end
		if (!(awready && wready))
			report_fault("write address and data were never accepted by the register block");
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		waited = 0;
		while (!bvalid && waited < HS_LIMIT)
		begin
			waited++;
			@(negedge clk);
		end
		if (!bvalid)
			report_fault("write got no response from the register block");
		resp = bresp;
	endtask

	task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int waited;
		waited = 0;
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		@(posedge clk);
		while (!arready && waited < HS_LIMIT)
		begin
			waited++;
			@(posedge clk);
		end
		if (!arready)
			report_fault("read address was never accepted by the register block");
		@(negedge clk);
		arvalid = 1'b0;
		waited = 0;
		while (!rvalid && waited < HS_LIMIT)
		begin
			waited++;
			@(negedge clk);
		end
		if (!rvalid)
			report_fault("read got no response from the register block");
		data = rdata;
		resp = rresp;
	endtask

	task automatic read_expect(input logic [ADDR_W-1:0] addr, input logic [31:0] exp,
		input string name);
		logic [31:0] data;
		logic [1:0]  resp;
		axi_read(addr, data, resp);
		check_word(name, data, exp);
		check_word("rresp", resp, RESP_OKAY);
	endtask

	task automatic set_master(input logic [3:0] keys, input logic [1:0] vol,
		input logic glide, input logic [7:0] div);
		reg_word_u  w;
		logic [1:0] resp;
		w.raw = '0;
		w.master.key_on = keys;
		w.master.volume = vol;
		w.master.glide_en = glide;
		w.master.glide_div = div;
		axi_write(ADDR_MASTER, w.raw, 4'hF, resp);
		check_word("master bresp", resp, RESP_OKAY);
	endtask

	task automatic set_voice(input logic [OCT_W-1:0] oct, input logic [3:0] tri_sel);
		reg_word_u  w;
		logic [1:0] resp;
		w.raw = '0;
		w.voice.octave = oct;
		w.voice.wave_tri = tri_sel;
		axi_write(ADDR_VOICE, w.raw, 4'hF, resp);
		check_word("voice bresp", resp, RESP_OKAY);
	endtask

	task automatic register_access();
		logic [31:0] data;
		logic [1:0]  resp;
		check_word("valid and ready after reset",
			{awready, wready, bvalid, arready, rvalid}, 32'h0);
		read_expect(ADDR_MASTER, 32'h0, "master after reset");
		read_expect(ADDR_VOICE, 32'h0, "voice after reset");
		read_expect(ADDR_STATUS, 32'h0, "status after reset");
		check_sample("audio_out after reset", audio_out, 8'h00);
		// bytes 1 and 3 stay masked
		axi_write(ADDR_MASTER, 32'hA5A5_5A5A, 4'b0101, resp);
		check_word("master bresp", resp, RESP_OKAY);
		read_expect(ADDR_MASTER, 32'h00A5_005A, "master strobed");
		axi_write(ADDR_VOICE, 32'h1234_5678, 4'b1010, resp);
		check_word("voice bresp", resp, RESP_OKAY);
		read_expect(ADDR_VOICE, 32'h1200_5600, "voice strobed");
		axi_write(ADDR_STATUS, 32'hFFFF_FFFF, 4'hF, resp);
		check_word("status write bresp", resp, RESP_SLVERR);
		axi_write(4'hC, 32'hFFFF_FFFF, 4'hF, resp);
		check_word("unmapped write bresp", resp, RESP_SLVERR);
		axi_read(4'hC, data, resp);
		check_word("unmapped rdata", data, 32'h0);
		check_word("unmapped rresp", resp, RESP_SLVERR);
		read_expect(ADDR_MASTER, 32'h00A5_005A, "master after bad writes");
		set_master(4'h0, 2'd0, 1'b0, 8'd0);
		set_voice(6'h00, 4'h0);
	endtask

	task automatic note_selection();
		logic [OCT_W-1:0]  octs [8] = '{6'h01, 6'h02, 6'h04, 6'h08, 6'h10, 6'h20, 6'h00, 6'h05};
		logic [NOTE_W-1:0] base;
		set_master(4'hF, 2'd0, 1'b0, 8'd0);
		foreach (octs[i])
		begin
			set_voice(octs[i], 4'h0);
			wait_cycles(4);
			base = expected_base(octs[i]);
			read_expect(ADDR_STATUS, pack_notes(base, base, base + 6'd12, base + 6'd12),
				"status notes");
		end
		// key 2 off, then keys 0 and 3 off
		set_master(4'b1011, 2'd0, 1'b0, 8'd0);
		wait_cycles(4);
		read_expect(ADDR_STATUS, pack_notes(base, base, 6'd0, base + 6'd12), "status key 2 off");
		set_master(4'b0110, 2'd0, 1'b0, 8'd0);
		wait_cycles(4);
		read_expect(ADDR_STATUS, pack_notes(6'd0, base, base + 6'd12, 6'd0), "status keys 0 3 off");
	endtask

	task automatic square_period(input logic [OCT_W-1:0] oct);
		int         nominal;
		int         since;
		int         rises;
		logic [7:0] prev;
		nominal = 65536 / int'(PHASE_INC[expected_base(oct)]);
		set_master(4'h0, 2'd0, 1'b0, 8'd0);
		set_voice(oct, 4'h0);
		set_master(4'b0001, 2'd0, 1'b0, 8'd0);
		prev = audio_out;
		since = 0;
		rises = 0;
		for (int c = 0; c < 4 * nominal && rises < 3; c++)
		begin
			@(negedge clk);
			since++;
			// one square voice at volume 0 is either silent or full scale
			if (audio_out != 8'd0)
				check_sample("audio_out square", audio_out, 8'd15);
			if (prev == 8'd0 && audio_out == 8'd15)
			begin
				// first edge only sets the reference point
				if (rises > 0 && (since < nominal - 1 || since > nominal + 1))
					check_word("square period", since, nominal);
				rises++;
				since = 0;
			end
			prev = audio_out;
		end
		if (rises < 3)
			report_fault("square output on voice 0 stopped toggling");
	endtask

	task automatic triangle_volume(input logic [1:0] vol);
		int          scale;
		int          level;
		logic [7:0]  peak;
		logic [15:0] levels_seen;
		scale = int'(vol) + 1;
		set_master(4'h0, 2'd0, 1'b0, 8'd0);
		set_voice(6'h20, 4'b0010);
		set_master(4'b0010, vol, 1'b0, 8'd0);
		wait_cycles(6);
		peak = '0;
		levels_seen = '0;
		// note 12 repeats every 512 cycles
		repeat (540)
		begin
			@(negedge clk);
			check_sample("audio_out triangle step", 8'(audio_out % scale), 8'd0);
			level = int'(audio_out) / scale;
			if (level < 16)
				levels_seen[level] = 1'b1;
			if (audio_out > peak)
				peak = audio_out;
		end
		check_sample("audio_out triangle peak", peak, 8'(15 * scale));
		// a triangle passes through every level, a square only the two ends
		check_word("triangle levels seen", levels_seen, 32'h0000_FFFF);
	endtask

	task automatic full_mix_peak();
		logic [7:0] peak;
		set_master(4'h0, 2'd0, 1'b0, 8'd0);
		set_voice(6'h20, 4'h0);
		set_master(4'hF, 2'd3, 1'b0, 8'd0);
		peak = '0;
		repeat (1100)
		begin
			@(negedge clk);
			if (audio_out > peak)
				peak = audio_out;
		end
		// all squares start in phase, so they all reach high together
		check_sample("audio_out mix peak", peak, 8'd240);
	endtask

	task automatic glide_steps();
		logic [31:0]       data;
		logic [1:0]        resp;
		logic [NOTE_W-1:0] last;
		logic [NOTE_W-1:0] cur;
		int                last_change;
		int                gap;
		int                steps;
		set_master(4'h0, 2'd0, 1'b0, 8'd0);
		set_voice(6'h01, 4'h0);
		set_master(4'b0001, 2'd0, 1'b1, 8'd9);
		wait_cycles(4);
		read_expect(ADDR_STATUS, pack_notes(6'd3, 6'd0, 6'd0, 6'd0), "glide start note");
		set_voice(6'h20, 4'h0);
		last = 6'd3;
		last_change = cycle_count;
		steps = 0;
		for (int polls = 0; polls < 200 && last != 6'd12; polls++)
		begin
			axi_read(ADDR_STATUS, data, resp);
			cur = data[NOTE_W-1:0];
			if (cur != last)
			begin
				check_word("voice 0 glide step", cur, last + 6'd1);
				gap = cycle_count - last_change;
				if (steps > 0 && (gap < 7 || gap > 13))
					check_word("glide step gap", gap, 10);
				steps++;
				last_change = cycle_count;
				last = cur;
			end
		end
		if (last != 6'd12)
			report_fault("voice 0 never reached note 12 while gliding");
		set_master(4'h0, 2'd0, 1'b1, 8'd9);
		// the read samples status two cycles after the key-off write
		wait_cycles(1);
		read_expect(ADDR_STATUS, 32'h0, "status after key-off");
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;
		wait_cycles(4);
		rst = 1'b0;

		register_access();
		note_selection();
		square_period(6'h20);
		square_period(6'h08);
		for (int v = 0; v < 4; v++)
			triangle_volume(2'(v));
		full_mix_peak();
		glide_steps();

		$display("value mismatches: %0d, other errors: %0d", mismatch_count, fault_count);
		if (mismatch_count == 0 && fault_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: src.f
src/synth_pkg.sv
src/synth_regs.sv
src/note_select.sv
src/portamento.sv
src/phase_gen.sv
src/wave_shaper.sv
src/voice_mixer.sv
src/synth_top.sv
sim/tb_synth.sv

// File: run_sim.sh
#!/bin/bash
# build and run the synth testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_synth -f src.f -o sim_synth \
	> build.log 2>&1 \
	&& ./obj_dir/sim_synth > sim.log 2>&1 \
	|| { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "\*\*\* TEST FAILED \*\*\*" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"
